/* rtl/flash_access_check.sv */
/* credit-based request queue, lookup stage and output register answering in request order
   the requester honours its ReqDepth credits, at most 7 response credits may be outstanding */
`timescale 1ns/1ps
`default_nettype none

module flash_access_check #(
  parameter int ReqDepth = 4
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       req_valid_i,
  input  flash_prot_pkg::info_addr_t req_addr_i,
  input  flash_prot_pkg::flash_op_t  req_op_i,
  output logic                       req_credit_o,
  input  flash_prot_pkg::info_page_cfg_t [flash_prot_pkg::InfosPerBank-1:0] bank0_cfgs_i,
  input  flash_prot_pkg::info_page_cfg_t [flash_prot_pkg::InfosPerBank-1:0] bank1_cfgs_i,
  input  logic                       resp_credit_i,
  output logic                       resp_valid_o,
  output logic                       resp_allow_o,
  output flash_prot_pkg::page_attr_t resp_attr_o
);

  import flash_prot_pkg::*;

  localparam int PtrW = (ReqDepth > 1) ? $clog2(ReqDepth) : 1;
  localparam logic [InfoPageW-1:0] SlotLimit = InfoPageW'(InfosPerBank);
  localparam logic [InfoPageW-1:0] ValidLimit = InfoPageW'(InfoPagesValid);

  // request queue
  info_addr_t  addr_mem [ReqDepth];
  flash_op_t   op_mem   [ReqDepth];
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  credit_cnt_t count_q;
  logic push, pop;

  // permission of the queue head, worked out in the cycle it is popped
  info_addr_t     head_addr;
  flash_op_t      head_op;
  info_page_cfg_t head_cfg;
  logic           head_right, head_allow;
  page_attr_t     head_attr;

  // lookup stage, which only fills while the output register is stalled
  logic lk_valid_q, lk_allow_q;
  page_attr_t lk_attr_q;

  // output register and response credits
  logic out_valid_q, out_allow_q;
  page_attr_t out_attr_q;
  credit_cnt_t resp_cred_q;
  logic resp_fire, out_free;
  logic load_out_lk, load_out_head, load_lk;

  // a full queue cannot take a request, this only happens if the requester breaks the protocol
  assign push = req_valid_i && (count_q != credit_cnt_t'(ReqDepth));
  assign pop  = (count_q != '0) && !lk_valid_q;
  // each pop frees one entry and hands a credit back straight away
  assign req_credit_o = pop;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(ReqDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(ReqDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + credit_cnt_t'(push) - credit_cnt_t'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      addr_mem[wr_ptr_q] <= req_addr_i;
      op_mem[wr_ptr_q]   <= req_op_i;
    end
  end

  assign head_addr = addr_mem[rd_ptr_q];
  assign head_op   = op_mem[rd_ptr_q];

  // bank bit is the top of the address, page index below it
  always_comb begin
    head_cfg = '0;
    if (head_addr[InfoPageW-1:0] < SlotLimit) begin
      if (head_addr[InfoPageW +: BankW] == 1'b0) begin
        head_cfg = bank0_cfgs_i[head_addr[InfoPageW-1:0]];
      end else begin
        head_cfg = bank1_cfgs_i[head_addr[InfoPageW-1:0]];
      end
    end
    unique case (head_op)
      OpRead:  head_right = head_cfg[CfgRd];
      OpProg:  head_right = head_cfg[CfgProg];
      OpErase: head_right = head_cfg[CfgErase];
      default: head_right = 1'b0;
    endcase
    head_allow = (head_addr[InfoPageW-1:0] < ValidLimit) && head_cfg[CfgEn] && head_right;
    // a refused access reveals nothing about the page attributes
    head_attr = head_allow ? {head_cfg[CfgHe], head_cfg[CfgEcc], head_cfg[CfgScr]} : '0;
  end

  // the output register frees up when it is empty or its response leaves this cycle
  assign resp_fire = out_valid_q && (resp_cred_q != '0);
  assign out_free  = !out_valid_q || resp_fire;

  // the stalled lookup entry always goes first to keep the order
  assign load_out_lk   = lk_valid_q && out_free;
  assign load_out_head = !lk_valid_q && pop && out_free;
  assign load_lk       = !lk_valid_q && pop && !out_free;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lk_valid_q  <= 1'b0;
      out_valid_q <= 1'b0;
      resp_cred_q <= '0;
    end else begin
      if (load_out_lk) begin
        lk_valid_q <= 1'b0;
      end else if (load_lk) begin
        lk_valid_q <= 1'b1;
      end
      if (out_free) begin
        out_valid_q <= load_out_lk || load_out_head;
      end
      resp_cred_q <= resp_cred_q + credit_cnt_t'(resp_credit_i) - credit_cnt_t'(resp_fire);
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_lk) begin
      lk_allow_q <= head_allow;
      lk_attr_q  <= head_attr;
    end
    if (load_out_lk) begin
      out_allow_q <= lk_allow_q;
      out_attr_q  <= lk_attr_q;
    end else if (load_out_head) begin
      out_allow_q <= head_allow;
      out_attr_q  <= head_attr;
    end
  end

  assign resp_valid_o = resp_fire;
  assign resp_allow_o = out_allow_q;
  assign resp_attr_o  = out_attr_q;

endmodule

`default_nettype wire

/* rtl/flash_info_cfg.sv */
/* combinational privilege filter for the info pages of one bank
   privilege inputs are expected to stay static while requests are in flight */
`timescale 1ns/1ps
`default_nettype none

module flash_info_cfg #(
  parameter logic [flash_prot_pkg::BankW-1:0] Bank = '0
) (
  input  flash_prot_pkg::info_page_cfg_t [flash_prot_pkg::InfosPerBank-1:0] cfgs_i,
  input  logic                                                               creator_seed_priv_i,
  input  logic                                                               owner_seed_priv_i,
  input  logic                                                               iso_flash_wr_en_i,
  input  logic                                                               iso_flash_rd_en_i,
  output flash_prot_pkg::info_page_cfg_t [flash_prot_pkg::InfosPerBank-1:0] cfgs_o
);

  import flash_prot_pkg::*;

  localparam int CfgW = $bits(info_page_cfg_t);

  // mask for the isolated page
  // enable and the attribute bits survive, access rights follow the isolation enables
  info_page_cfg_t iso_mask;

  always_comb begin
    iso_mask           = '0;
    iso_mask[CfgEn]    = 1'b1;
    iso_mask[CfgRd]    = iso_flash_rd_en_i;
    iso_mask[CfgProg]  = iso_flash_wr_en_i;
    iso_mask[CfgErase] = iso_flash_wr_en_i;
    iso_mask[CfgScr]   = 1'b1;
    iso_mask[CfgEcc]   = 1'b1;
    iso_mask[CfgHe]    = 1'b1;
  end

  for (genvar i = 0; i < InfosPerBank; i++) begin : gen_page
    localparam logic [InfoPageW-1:0] CurPage = InfoPageW'(i);

    if (i >= InfoPagesValid) begin : gen_invalid
      // no flash behind these slots
      assign cfgs_o[i] = '0;
    end else if (Bank == SeedBank && CurPage == CreatorSeedPage) begin : gen_creator
      // creator seed page is wiped unless the creator privilege is held
      assign cfgs_o[i] = cfgs_i[i] & {CfgW{creator_seed_priv_i}};
    end else if (Bank == SeedBank && CurPage == OwnerSeedPage) begin : gen_owner
      // same rule for the owner seed page under the owner privilege
      assign cfgs_o[i] = cfgs_i[i] & {CfgW{owner_seed_priv_i}};
    end else if (Bank == SeedBank && CurPage == IsolatedPage) begin : gen_isolated
      assign cfgs_o[i] = cfgs_i[i] & iso_mask;
    end else begin : gen_normal
      assign cfgs_o[i] = cfgs_i[i];
    end
  end

  // the other bank has no privileged pages
  // its privilege inputs and the isolation mask end in a dead sink
  if (Bank != SeedBank) begin : gen_tieoff
    logic [1:0]     unused_seed_privs;
    info_page_cfg_t unused_iso_mask;

    assign unused_seed_privs = {owner_seed_priv_i, creator_seed_priv_i};
    assign unused_iso_mask   = iso_mask;
  end

endmodule

`default_nettype wire

/* rtl/flash_info_regs.sv */
/* software-written page configuration with per-page write locks, cleared by reset
   writes to invalid slots or locked pages are silently dropped, no write response exists */
`timescale 1ns/1ps
`default_nettype none

module flash_info_regs (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           cfg_we_i,
  input  logic                           cfg_lock_i,
  input  flash_prot_pkg::info_addr_t     cfg_addr_i,
  input  flash_prot_pkg::info_page_cfg_t cfg_wdata_i,
  output flash_prot_pkg::info_page_cfg_t [flash_prot_pkg::InfosPerBank-1:0] bank0_cfgs_o,
  output flash_prot_pkg::info_page_cfg_t [flash_prot_pkg::InfosPerBank-1:0] bank1_cfgs_o
);

  import flash_prot_pkg::*;

  // write address split into its bank and page fields
  logic [BankW-1:0]     wr_bank;
  logic [InfoPageW-1:0] wr_page;

  // storage exists only for implemented pages
  info_page_cfg_t cfg_q  [NumBanks][InfoPagesValid];
  logic           lock_q [NumBanks][InfoPagesValid];

  // per-bank view including the unimplemented slots
  info_page_cfg_t [InfosPerBank-1:0] bank_cfgs [NumBanks];

  assign wr_bank = cfg_addr_i[InfoPageW +: BankW];
  assign wr_page = cfg_addr_i[InfoPageW-1:0];

  // a page only takes a write while its lock is clear
  // the lock flag is written together with the data, so it latches on the locking write
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int b = 0; b < NumBanks; b++) begin
        for (int p = 0; p < InfoPagesValid; p++) begin
          cfg_q[b][p]  <= '0;
          lock_q[b][p] <= 1'b0;
        end
      end
    end else if (cfg_we_i) begin
      // page numbers 8 to 15 never match a stored page and fall away here
      for (int b = 0; b < NumBanks; b++) begin
        for (int p = 0; p < InfoPagesValid; p++) begin
          if (wr_bank == BankW'(b) && wr_page == InfoPageW'(p) && !lock_q[b][p]) begin
            cfg_q[b][p]  <= cfg_wdata_i;
            lock_q[b][p] <= cfg_lock_i;
          end
        end
      end
    end
  end

  // invalid slots read back as zero
  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    for (genvar p = 0; p < InfosPerBank; p++) begin : gen_slot
      if (p < InfoPagesValid) begin : gen_valid
        assign bank_cfgs[b][p] = cfg_q[b][p];
      end else begin : gen_invalid
        assign bank_cfgs[b][p] = '0;
      end
    end
  end

  assign bank0_cfgs_o = bank_cfgs[0];
  assign bank1_cfgs_o = bank_cfgs[1];

endmodule

`default_nettype wire

/* rtl/flash_prot_pkg.sv */
/* shared widths, page rights layout and operation codes for the info-page protection path
   two banks with one info partition each, seed and isolated pages are fixed in bank 0 */
`default_nettype none

package flash_prot_pkg;

  // bank organisation
  parameter int NumBanks = 2;
  parameter int BankW = 1;

  // each bank reserves ten page slots but only the lower eight are implemented
  parameter int InfosPerBank = 10;
  parameter int InfoPageW = 4;
  parameter int InfoPagesValid = 8;

  // page address with the bank index sitting above the page index
  typedef logic [BankW+InfoPageW-1:0] info_addr_t;

  // rights and attributes of one info page, indexed by the Cfg* positions below
  typedef logic [6:0] info_page_cfg_t;

  parameter int CfgEn = 0;
  parameter int CfgRd = 1;
  parameter int CfgProg = 2;
  parameter int CfgErase = 3;
  parameter int CfgScr = 4;
  parameter int CfgEcc = 5;
  parameter int CfgHe = 6;

  // attributes returned with a response
  // bit 0 is scramble, bit 1 is ECC and bit 2 is high endurance
  typedef logic [2:0] page_attr_t;

  // flash operation requested against a page
  typedef logic [1:0] flash_op_t;

  parameter flash_op_t OpRead = 2'd0;
  parameter flash_op_t OpProg = 2'd1;
  parameter flash_op_t OpErase = 2'd2;
  // code 3 has no operation behind it and is always refused

  // location of the privileged pages
  // all of them live in the seed bank
  parameter logic [BankW-1:0] SeedBank = 1'b0;
  parameter logic [InfoPageW-1:0] CreatorSeedPage = 4'd1;
  parameter logic [InfoPageW-1:0] OwnerSeedPage = 4'd2;
  parameter logic [InfoPageW-1:0] IsolatedPage = 4'd3;

  // counter for queue occupancy and response credits
  // three bits cover request queues of up to four entries
  typedef logic [2:0] credit_cnt_t;

endpackage

`default_nettype wire

/* rtl/flash_prot_top.sv */
/* info-page protection path for two flash banks with one info partition each
   privilege inputs may only change while no request is outstanding */
`timescale 1ns/1ps
`default_nettype none

module flash_prot_top #(
  parameter int ReqDepth = 4
) (
  input  logic                           clk_i,
  input  logic                           reset_i,
  // configuration write port
  input  logic                           cfg_we_i,
  input  flash_prot_pkg::info_addr_t     cfg_addr_i,
  input  flash_prot_pkg::info_page_cfg_t cfg_wdata_i,
  input  logic                           cfg_lock_i,
  // static privilege levels
  input  logic                           creator_seed_priv_i,
  input  logic                           owner_seed_priv_i,
  input  logic                           iso_flash_rd_en_i,
  input  logic                           iso_flash_wr_en_i,
  // request channel
  input  logic                           req_valid_i,
  input  flash_prot_pkg::info_addr_t     req_addr_i,
  input  flash_prot_pkg::flash_op_t      req_op_i,
  output logic                           req_credit_o,
  // response channel
  input  logic                           resp_credit_i,
  output logic                           resp_valid_o,
  output logic                           resp_allow_o,
  output flash_prot_pkg::page_attr_t     resp_attr_o
);

  import flash_prot_pkg::*;

  // raw configuration from software and the view after privilege filtering
  info_page_cfg_t [InfosPerBank-1:0] reg_bank0_cfgs, reg_bank1_cfgs;
  info_page_cfg_t [InfosPerBank-1:0] flt_bank0_cfgs, flt_bank1_cfgs;

  flash_info_regs flash_info_regs_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .cfg_we_i     (cfg_we_i),
    .cfg_lock_i   (cfg_lock_i),
    .cfg_addr_i   (cfg_addr_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .bank0_cfgs_o (reg_bank0_cfgs),
    .bank1_cfgs_o (reg_bank1_cfgs)
  );

  // bank 0 carries the seed and isolated pages
  flash_info_cfg #(
    .Bank (1'b0)
  ) flash_info_cfg_bank0_i (
    .cfgs_i              (reg_bank0_cfgs),
    .creator_seed_priv_i (creator_seed_priv_i),
    .owner_seed_priv_i   (owner_seed_priv_i),
    .iso_flash_wr_en_i   (iso_flash_wr_en_i),
    .iso_flash_rd_en_i   (iso_flash_rd_en_i),
    .cfgs_o              (flt_bank0_cfgs)
  );

  flash_info_cfg #(
    .Bank (1'b1)
  ) flash_info_cfg_bank1_i (
    .cfgs_i              (reg_bank1_cfgs),
    .creator_seed_priv_i (creator_seed_priv_i),
    .owner_seed_priv_i   (owner_seed_priv_i),
    .iso_flash_wr_en_i   (iso_flash_wr_en_i),
    .iso_flash_rd_en_i   (iso_flash_rd_en_i),
    .cfgs_o              (flt_bank1_cfgs)
  );

  flash_access_check #(
    .ReqDepth (ReqDepth)
  ) flash_access_check_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_valid_i   (req_valid_i),
    .req_addr_i    (req_addr_i),
    .req_op_i      (req_op_i),
    .req_credit_o  (req_credit_o),
    .bank0_cfgs_i  (flt_bank0_cfgs),
    .bank1_cfgs_i  (flt_bank1_cfgs),
    .resp_credit_i (resp_credit_i),
    .resp_valid_o  (resp_valid_o),
    .resp_allow_o  (resp_allow_o),
    .resp_attr_o   (resp_attr_o)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it, the exit status is nonzero on any failure
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module flash_prot_tb \
  -f verilog.f -o flash_prot_sim > build.log 2>&1 &&
  ./obj_dir/flash_prot_sim > "$LOG" 2>&1 ||
  { cat build.log "$LOG" 2>/dev/null; echo "build or simulation error"; exit 1; }

cat "$LOG"
grep -q "Regression failed" "$LOG" && { echo "FAIL"; exit 1; }
grep -q "Regression passed" "$LOG" || { echo "FAIL: run did not complete"; exit 1; }
echo "PASS"

/* verif/flash_prot_assertions.sv */
/* concurrent checks on the access checker, bound into every flash_access_check instance
   queue occupancy is probed inside the checker, response credits are counted from the pins */
`timescale 1ns/1ps
`default_nettype none

module flash_prot_assertions #(
  parameter int ReqDepth = 4
) (
  input logic                        clk_i,
  input logic                        reset_i,
  input logic                        req_valid_i,
  input logic                        req_credit_i,
  input flash_prot_pkg::credit_cnt_t count_i,
  input logic                        resp_credit_i,
  input logic                        resp_valid_i,
  input logic                        resp_allow_i,
  input flash_prot_pkg::page_attr_t  resp_attr_i
);

  import flash_prot_pkg::*;

  // response credits granted on resp_credit_i and not yet spent by a response
  int granted_cnt;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      granted_cnt <= 0;
    end else begin
      granted_cnt <= granted_cnt + (resp_credit_i ? 1 : 0) - (resp_valid_i ? 1 : 0);
    end
  end

  // a new request only arrives while the queue still has a free entry
  assert property (@(posedge clk_i) disable iff (reset_i)
                   req_valid_i |-> count_i < credit_cnt_t'(ReqDepth))
    else $error("request arrived while the queue already held ReqDepth entries");

  // each response spends a credit that was granted earlier
  assert property (@(posedge clk_i) disable iff (reset_i) resp_valid_i |-> granted_cnt != 0)
    else $error("response sent without a response credit");

  // a refused access must not leak page attributes
  assert property (@(posedge clk_i) disable iff (reset_i)
                   resp_valid_i && !resp_allow_i |-> resp_attr_i == '0)
    else $error("denied response carries nonzero attributes");

  // both channel strobes are quiet right after a reset cycle
  assert property (@(posedge clk_i) reset_i |=> !resp_valid_i && !req_credit_i)
    else $error("strobe active in the cycle after reset");

endmodule

bind flash_access_check flash_prot_assertions #(
  .ReqDepth (ReqDepth)
) flash_prot_assertions_i (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .req_valid_i   (req_valid_i),
  .req_credit_i  (req_credit_o),
  .count_i       (count_q),
  .resp_credit_i (resp_credit_i),
  .resp_valid_i  (resp_valid_o),
  .resp_allow_i  (resp_allow_o),
  .resp_attr_i   (resp_attr_o)
);

`default_nettype wire

/* verif/flash_prot_tb.sv */
/* table-driven testbench for the info-page protection path, the requester honours checker credits
   privileges and writes change only once all responses are back, one segment withholds credits */
`timescale 1ns/1ps
`default_nettype none

module flash_prot_tb;

  import flash_prot_pkg::*;

  localparam int ReqDepth = 4;
  localparam int unsigned Seed = 32'hec97_76ad;

  // one table row, privileges ordered as creator, owner, isolation read, isolation write
  typedef struct packed {
    logic [3:0]     privs;
    logic           we;
    logic           lock;
    info_page_cfg_t wdata;
    info_addr_t     addr;
    flash_op_t      op;
    logic           allow;
    page_attr_t     attr;
    logic           burst;
  } row_t;

  logic           clk_i = 1'b0;
  logic           reset_i;
  logic           cfg_we_i;
  info_addr_t     cfg_addr_i;
  info_page_cfg_t cfg_wdata_i;
  logic           cfg_lock_i;
  logic           creator_seed_priv_i;
  logic           owner_seed_priv_i;
  logic           iso_flash_rd_en_i;
  logic           iso_flash_wr_en_i;
  logic           req_valid_i;
  info_addr_t     req_addr_i;
  flash_op_t      req_op_i;
  logic           req_credit_o;
  logic           resp_credit_i;
  logic           resp_valid_o;
  logic           resp_allow_o;
  page_attr_t     resp_attr_o;

  row_t  tbl [$];
  string row_names [$];
  // table index of every issued request, in issue order
  int    expected [$];
  bit    table_done = 1'b0;
  bit    hold_credits = 1'b0;

  // the main process owns issue counts, the monitor owns everything it observes
  int reqs_issued = 0;
  int credits_returned = 0;
  int pulses = 0;
  int responses_seen = 0;
  int burst_base = 0;
  int burst_resp_base = 0;
  int errors_main = 0;
  int errors_mon = 0;

  always #5 clk_i = ~clk_i;

  flash_prot_top #(
    .ReqDepth (ReqDepth)
  ) flash_prot_top_i (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .cfg_we_i            (cfg_we_i),
    .cfg_addr_i          (cfg_addr_i),
    .cfg_wdata_i         (cfg_wdata_i),
    .cfg_lock_i          (cfg_lock_i),
    .creator_seed_priv_i (creator_seed_priv_i),
    .owner_seed_priv_i   (owner_seed_priv_i),
    .iso_flash_rd_en_i   (iso_flash_rd_en_i),
    .iso_flash_wr_en_i   (iso_flash_wr_en_i),
    .req_valid_i         (req_valid_i),
    .req_addr_i          (req_addr_i),
    .req_op_i            (req_op_i),
    .req_credit_o        (req_credit_o),
    .resp_credit_i       (resp_credit_i),
    .resp_valid_o        (resp_valid_o),
    .resp_allow_o        (resp_allow_o),
    .resp_attr_o         (resp_attr_o)
  );

  task automatic add_row(input string name, input logic [3:0] privs, input logic we,
                         input logic lock, input info_page_cfg_t wdata, input info_addr_t addr,
                         input flash_op_t op, input logic allow, input page_attr_t attr,
                         input logic burst);
    row_t r;
    r = '{privs, we, lock, wdata, addr, op, allow, attr, burst};
    tbl.push_back(r);
    row_names.push_back(name);
  endtask

  // expected values follow from the page rights, cfg bits are He Ecc Scr Erase Prog Rd En
  task automatic build_table();
    add_row("b0p0_read", 4'b1111, 1'b1, 1'b0, 7'b101_0011, 5'h00, OpRead, 1'b1, 3'b101, 1'b0);
    add_row("b0p0_prog_denied", 4'b1111, 1'b0, 1'b0, 7'h00, 5'h00, OpProg, 1'b0, 3'b000, 1'b0);
    add_row("b1p5_erase", 4'b1111, 1'b1, 1'b0, 7'b011_1001, 5'h15, OpErase, 1'b1, 3'b011, 1'b0);
    add_row("b1p5_read_denied", 4'b1111, 1'b0, 1'b0, 7'h00, 5'h15, OpRead, 1'b0, 3'b000, 1'b0);
    add_row("b1p7_disabled", 4'b1111, 1'b1, 1'b0, 7'b111_1110, 5'h17, OpRead, 1'b0, 3'b000, 1'b0);
    // seed pages in bank 0 and the same slots in bank 1
    add_row("creator_priv_on", 4'b1111, 1'b1, 1'b0, 7'h7f, 5'h01, OpRead, 1'b1, 3'b111, 1'b0);
    add_row("creator_priv_off", 4'b0111, 1'b0, 1'b0, 7'h00, 5'h01, OpProg, 1'b0, 3'b000, 1'b0);
    add_row("owner_priv_on", 4'b1111, 1'b1, 1'b0, 7'b010_0111, 5'h02, OpProg, 1'b1, 3'b010, 1'b0);
    add_row("owner_priv_off", 4'b1011, 1'b0, 1'b0, 7'h00, 5'h02, OpRead, 1'b0, 3'b000, 1'b0);
    add_row("b1_creator_slot", 4'b0011, 1'b1, 1'b0, 7'b100_0011, 5'h11, OpRead, 1'b1, 3'b100, 1'b0);
    add_row("b1_owner_slot", 4'b0011, 1'b1, 1'b0, 7'b001_0101, 5'h12, OpProg, 1'b1, 3'b001, 1'b0);
    // isolated page limited by both the isolation enables and its own rights
    add_row("iso_read_en", 4'b1110, 1'b1, 1'b0, 7'b110_1111, 5'h03, OpRead, 1'b1, 3'b110, 1'b0);
    add_row("iso_prog_wr_off", 4'b1110, 1'b0, 1'b0, 7'h00, 5'h03, OpProg, 1'b0, 3'b000, 1'b0);
    add_row("iso_read_off", 4'b1101, 1'b0, 1'b0, 7'h00, 5'h03, OpRead, 1'b0, 3'b000, 1'b0);
    add_row("iso_erase_wr_en", 4'b1101, 1'b0, 1'b0, 7'h00, 5'h03, OpErase, 1'b1, 3'b110, 1'b0);
    add_row("iso_cfg_limits", 4'b1111, 1'b1, 1'b0, 7'b001_0011, 5'h03, OpErase, 1'b0, 3'b000, 1'b0);
    add_row("iso_cfg_read", 4'b1111, 1'b0, 1'b0, 7'h00, 5'h03, OpRead, 1'b1, 3'b001, 1'b0);
    // invalid slots, the unused op code and page locks
    add_row("slot8_invalid", 4'b1111, 1'b1, 1'b0, 7'h7f, 5'h08, OpRead, 1'b0, 3'b000, 1'b0);
    add_row("slot9_invalid_b1", 4'b1111, 1'b0, 1'b0, 7'h00, 5'h19, OpRead, 1'b0, 3'b000, 1'b0);
    add_row("page12_out_of_range", 4'b1111, 1'b0, 1'b0, 7'h00, 5'h0c, OpRead, 1'b0, 3'b000, 1'b0);
    add_row("op3_denied", 4'b1111, 1'b1, 1'b0, 7'h7f, 5'h06, 2'd3, 1'b0, 3'b000, 1'b0);
    add_row("op_read_b0p6", 4'b1111, 1'b0, 1'b0, 7'h00, 5'h06, OpRead, 1'b1, 3'b111, 1'b0);
    add_row("lock_write", 4'b1111, 1'b1, 1'b1, 7'b000_0101, 5'h04, OpProg, 1'b1, 3'b000, 1'b0);
    add_row("locked_ignored", 4'b1111, 1'b1, 1'b0, 7'h7f, 5'h04, OpRead, 1'b0, 3'b000, 1'b0);
    add_row("locked_prog", 4'b1111, 1'b0, 1'b0, 7'h00, 5'h04, OpProg, 1'b1, 3'b000, 1'b0);
    // burst against earlier pages while response credits are held back
    add_row("burst_b0p0_read", 4'b1111, 1'b0, 1'b0, 7'h00, 5'h00, OpRead, 1'b1, 3'b101, 1'b1);
    add_row("burst_b1p5_erase", 4'b1111, 1'b0, 1'b0, 7'h00, 5'h15, OpErase, 1'b1, 3'b011, 1'b1);
    add_row("burst_b1p7_read", 4'b1111, 1'b0, 1'b0, 7'h00, 5'h17, OpRead, 1'b0, 3'b000, 1'b1);
    add_row("burst_creator_erase", 4'b1111, 1'b0, 1'b0, 7'h00, 5'h01, OpErase, 1'b1, 3'b111, 1'b1);
    add_row("burst_owner_erase", 4'b1111, 1'b0, 1'b0, 7'h00, 5'h02, OpErase, 1'b0, 3'b000, 1'b1);
    add_row("burst_b1p1_read", 4'b1111, 1'b0, 1'b0, 7'h00, 5'h11, OpRead, 1'b1, 3'b100, 1'b1);
    add_row("burst_iso_read", 4'b1111, 1'b0, 1'b0, 7'h00, 5'h03, OpRead, 1'b1, 3'b001, 1'b1);
    add_row("burst_b0p6_prog", 4'b1111, 1'b0, 1'b0, 7'h00, 5'h06, OpProg, 1'b1, 3'b111, 1'b1);
    add_row("burst_b0p4_prog", 4'b1111, 1'b0, 1'b0, 7'h00, 5'h04, OpProg, 1'b1, 3'b000, 1'b1);
    add_row("burst_b1p2_prog", 4'b1111, 1'b0, 1'b0, 7'h00, 5'h12, OpProg, 1'b1, 3'b001, 1'b1);
    add_row("burst_b1p0_unwritten", 4'b1111, 1'b0, 1'b0, 7'h00, 5'h10, OpRead, 1'b0, 3'b000, 1'b1);
  endtask

  task automatic wait_drain();
    while (responses_seen != reqs_issued) begin
      @(negedge clk_i);
    end
  endtask

  task automatic write_cfg(input int idx);
    cfg_we_i    = 1'b1;
    cfg_addr_i  = tbl[idx].addr;
    cfg_wdata_i = tbl[idx].wdata;
    cfg_lock_i  = tbl[idx].lock;
    @(negedge clk_i);
    cfg_we_i   = 1'b0;
    cfg_lock_i = 1'b0;
  endtask

  // with all credits spent the checker must stay silent until credits come back
  task automatic check_stall();
    repeat (20) @(negedge clk_i);
    assert (reqs_issued - burst_base == ReqDepth + 2) else begin
      errors_main++;
      $display("error burst_fill: requests expected %0d actual %0d", ReqDepth + 2,
               reqs_issued - burst_base);
    end
    assert (ReqDepth + credits_returned - reqs_issued == 0) else begin
      errors_main++;
      $display("a request credit came back while the pipeline was full");
    end
    assert (responses_seen == burst_resp_base) else begin
      errors_main++;
      $display("a response appeared while response credits were held back");
    end
    hold_credits = 1'b0;
  endtask

  task automatic issue_request(input int idx);
    while (ReqDepth + credits_returned - reqs_issued <= 0) begin
      if (hold_credits) begin
        check_stall();
      end
      @(negedge clk_i);
    end
    req_valid_i = 1'b1;
    req_addr_i  = tbl[idx].addr;
    req_op_i    = tbl[idx].op;
    expected.push_back(idx);
    reqs_issued++;
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  task automatic check_response();
    int idx;
    assert (pulses > responses_seen) else begin
      errors_mon++;
      $display("a response was sent without a response credit");
    end
    assert (responses_seen < expected.size()) else begin
      errors_mon++;
      $display("a response arrived with no request outstanding");
    end
    if (responses_seen < expected.size()) begin
      idx = expected[responses_seen];
      assert (resp_allow_o == tbl[idx].allow) else begin
        errors_mon++;
        $display("error %s: allow expected %0b actual %0b", row_names[idx], tbl[idx].allow,
                 resp_allow_o);
      end
      assert (resp_attr_o == tbl[idx].attr) else begin
        errors_mon++;
        $display("error %s: attr expected %03b actual %03b", row_names[idx], tbl[idx].attr,
                 resp_attr_o);
      end
    end
    responses_seen++;
  endtask

  initial begin : main
    row_t       r;
    logic [3:0] cur_privs;
    bit         in_burst;
    reset_i     = 1'b1;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = '0;
    cfg_wdata_i = '0;
    cfg_lock_i  = 1'b0;
    req_valid_i = 1'b0;
    req_addr_i  = '0;
    req_op_i    = OpRead;
    {creator_seed_priv_i, owner_seed_priv_i, iso_flash_rd_en_i, iso_flash_wr_en_i} = 4'b0000;
    cur_privs = 4'b0000;
    in_burst  = 1'b0;
    build_table();
    table_done = 1'b1;
    repeat (8) @(negedge clk_i);
    reset_i = 1'b0;
    for (int i = 0; i < tbl.size(); i++) begin
      r = tbl[i];
      // no lookup may be pending while the page view it depends on changes
      if (r.privs != cur_privs || r.we || (r.burst && !in_burst)) begin
        wait_drain();
      end
      if (r.privs != cur_privs) begin
        {creator_seed_priv_i, owner_seed_priv_i, iso_flash_rd_en_i, iso_flash_wr_en_i} = r.privs;
        cur_privs = r.privs;
      end
      if (r.we) begin
        write_cfg(i);
      end
      if (r.burst && !in_burst) begin
        in_burst        = 1'b1;
        hold_credits    = 1'b1;
        burst_base      = reqs_issued;
        burst_resp_base = responses_seen;
      end
      issue_request(i);
    end
    wait_drain();
    // a few idle cycles to catch a duplicated response
    repeat (10) @(negedge clk_i);
    $display("errors: %0d, responses checked: %0d", errors_main + errors_mon, responses_seen);
    if (errors_main + errors_mon == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // monitor and response credit source share one process so their counts never race
  initial begin : monitor
    int gap;
    resp_credit_i = 1'b0;
    gap = 0;
    void'($urandom(Seed));
    forever begin
      @(negedge clk_i);
      resp_credit_i = 1'b0;
      if (!reset_i) begin
        if (req_credit_o) begin
          credits_returned++;
        end
        if (resp_valid_o) begin
          check_response();
        end
        // never grant more credits than there are requests, the checker counter is narrow
        if (gap > 0) begin
          gap--;
        end else if (!hold_credits && pulses < reqs_issued) begin
          resp_credit_i = 1'b1;
          pulses++;
          gap = int'($urandom % 4);
        end
      end
    end
  end

  initial begin : watchdog
    wait (table_done);
    repeat (200 * tbl.size() + 1000) @(posedge clk_i);
    $display("timeout with %0d of %0d responses received", responses_seen, reqs_issued);
    $display("errors: %0d, responses checked: %0d", errors_main + errors_mon, responses_seen);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
rtl/flash_prot_pkg.sv
rtl/flash_info_regs.sv
rtl/flash_info_cfg.sv
rtl/flash_access_check.sv
rtl/flash_prot_top.sv
verif/flash_prot_assertions.sv
verif/flash_prot_tb.sv
